// File: mem1r2w_params.svh
`ifndef MEM1R2W_PARAMS_SVH
`define MEM1R2W_PARAMS_SVH

// Data word width in bits
`define MEM_WIDTH 15

// Address width, sized to MEM_NUMADDR
`define MEM_BITADDR 8

// Number of words in the physical macro
`define MEM_NUMADDR 256

// Macro read latency in cycles, at least 1
`define MEM_T1_DELAY 1

// Output register stages in the wrapper
`define MEM_FLOPOUT 1

`endif

// File: mem1r2w_pkg.sv
`default_nettype none

`include "mem1r2w_params.svh"

package mem1r2w_pkg;

  // Logical read port, also macro port C
  typedef struct packed {
    logic                    read;
    logic [`MEM_BITADDR-1:0] adr;
  } rd_req_t;

  // Logical write ports 0/1, macro ports A/B
  typedef struct packed {
    logic                    write;
    logic [`MEM_BITADDR-1:0] adr;
    logic [`MEM_WIDTH-1:0]   din;
    logic [`MEM_WIDTH-1:0]   bw;  // Per-bit write enable
  } wr_req_t;

  // Logical read response
  typedef struct packed {
    logic                  vld;
    logic [`MEM_WIDTH-1:0] dout;
  } rd_rsp_t;

endpackage

`default_nettype wire

// File: t1_mem_1r2w.sv
`default_nettype none

`include "mem1r2w_params.svh"

module t1_mem_1r2w
  import mem1r2w_pkg::*;
#(
  parameter int WIDTH   = `MEM_WIDTH,
  parameter int BITADDR = `MEM_BITADDR,
  parameter int NUMADDR = `MEM_NUMADDR,
  parameter int DELAY   = `MEM_T1_DELAY
) (
  input  logic             clk,
  input  rd_req_t          t1_rd,
  input  wr_req_t          t1_wr_a,
  input  wr_req_t          t1_wr_b,
  output logic [WIDTH-1:0] t1_dout
);

  logic [WIDTH-1:0]   mem [NUMADDR];
  logic [WIDTH-1:0]   rd_pipe [DELAY];
  logic [BITADDR-1:0] adr_a;
  logic [BITADDR-1:0] adr_b;
  logic [BITADDR-1:0] adr_c;
  logic               same_adr;
  logic [WIDTH-1:0]   word_a;
  logic [WIDTH-1:0]   word_b;

  function automatic logic [WIDTH-1:0] merge(
    input logic [WIDTH-1:0] old_word,
    input logic [WIDTH-1:0] din,
    input logic [WIDTH-1:0] bw
  );
    return (old_word & ~bw) | (din & bw);
  endfunction

  if (DELAY < 1) begin : g_bad_delay
    $error("t1_mem_1r2w needs DELAY of at least 1");
  end

  assign adr_a = t1_wr_a.adr;
  assign adr_b = t1_wr_b.adr;
  assign adr_c = t1_rd.adr;

  assign same_adr = t1_wr_a.write && t1_wr_b.write && (adr_a == adr_b);

  // B wins over A, A wins over old contents
  always_comb begin
    word_a = merge(mem[adr_a], t1_wr_a.din, t1_wr_a.bw);
    word_b = merge(mem[adr_b], t1_wr_b.din, t1_wr_b.bw);
    if (same_adr) begin
      word_b = merge(word_a, t1_wr_b.din, t1_wr_b.bw);  // Layer B over merged A
    end
  end

  always_ff @(posedge clk) begin
    if (t1_wr_a.write && !same_adr) begin
      mem[adr_a] <= word_a;
    end
    if (t1_wr_b.write) begin
      mem[adr_b] <= word_b;
    end
  end

  // Sampled before this edge's writes land, so old data on collision
  always_ff @(posedge clk) begin
    if (t1_rd.read) begin
      rd_pipe[0] <= mem[adr_c];
    end
    for (int i = 1; i < DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign t1_dout = rd_pipe[DELAY-1];

  // Any active strobe needs a known address
  a_known_adr: assert property (@(posedge clk)
    (!t1_rd.read    || !$isunknown(adr_c)) &&
    (!t1_wr_a.write || !$isunknown(adr_a)) &&
    (!t1_wr_b.write || !$isunknown(adr_b)))
    else $error("t1_mem_1r2w: unknown address with strobe high");

endmodule

`default_nettype wire

// File: algo_1r2w_wrap.sv
`default_nettype none

`include "mem1r2w_params.svh"

module algo_1r2w_wrap
  import mem1r2w_pkg::*;
#(
  parameter int T1_DELAY = `MEM_T1_DELAY,
  parameter int FLOPOUT  = `MEM_FLOPOUT
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rd_req_t               rd_req,
  input  wr_req_t               wr_req0,
  input  wr_req_t               wr_req1,
  output rd_rsp_t               rd_rsp,
  output rd_req_t               t1_rd,
  output wr_req_t               t1_wr_a,
  output wr_req_t               t1_wr_b,
  input  logic [`MEM_WIDTH-1:0] t1_dout
);

  localparam int LAT = T1_DELAY + FLOPOUT;  // Read to valid latency

  logic                  rsp_vld;
  logic [`MEM_WIDTH-1:0] rsp_dout;

  // No banking, ports map one to one
  assign t1_rd   = rd_req;
  assign t1_wr_a = wr_req0;
  assign t1_wr_b = wr_req1;

  if (LAT > 0) begin : g_vld
    logic [LAT-1:0] vld_sr;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        vld_sr <= '0;
      end else begin
        vld_sr[0] <= rd_req.read;
        for (int i = 1; i < LAT; i++) begin
          vld_sr[i] <= vld_sr[i-1];
        end
      end
    end

    assign rsp_vld = vld_sr[LAT-1];

    // Valid tracks the strobe through macro plus output stages
    a_vld_lat: assert property (@(posedge clk) disable iff (!arst_n)
      ##LAT (rsp_vld == $past(rd_req.read, LAT)))
      else $error("algo_1r2w_wrap: rd_rsp.vld out of step with read");
  end else begin : g_no_vld
    assign rsp_vld = rd_req.read;
  end

  if (FLOPOUT > 0) begin : g_flopout
    logic [`MEM_WIDTH-1:0] dout_sr [FLOPOUT];

    always_ff @(posedge clk) begin
      dout_sr[0] <= t1_dout;
      for (int i = 1; i < FLOPOUT; i++) begin
        dout_sr[i] <= dout_sr[i-1];
      end
    end

    assign rsp_dout = dout_sr[FLOPOUT-1];
  end else begin : g_no_flopout
    assign rsp_dout = t1_dout;
  end

  assign rd_rsp = '{vld: rsp_vld, dout: rsp_dout};

  // Macro must return written data by the time valid shows
  a_dout_known: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld |-> !$isunknown(rsp_dout))
    else $error("algo_1r2w_wrap: rd_rsp.dout unknown with vld high");

endmodule

`default_nettype wire

// File: mem1r2w_top.sv
`default_nettype none

`include "mem1r2w_params.svh"

module mem1r2w_top
  import mem1r2w_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  rd_req_t rd_req,
  input  wr_req_t wr_req0,
  input  wr_req_t wr_req1,
  output rd_rsp_t rd_rsp
);

  rd_req_t               t1_rd;    // Port C
  wr_req_t               t1_wr_a;  // Port A
  wr_req_t               t1_wr_b;  // Port B
  logic [`MEM_WIDTH-1:0] t1_dout;

  algo_1r2w_wrap #(
    .T1_DELAY (`MEM_T1_DELAY),
    .FLOPOUT  (`MEM_FLOPOUT)
  ) i_algo_1r2w_wrap (
    .clk     (clk),
    .arst_n  (arst_n),
    .rd_req  (rd_req),
    .wr_req0 (wr_req0),
    .wr_req1 (wr_req1),
    .rd_rsp  (rd_rsp),
    .t1_rd   (t1_rd),
    .t1_wr_a (t1_wr_a),
    .t1_wr_b (t1_wr_b),
    .t1_dout (t1_dout)
  );

  t1_mem_1r2w #(
    .WIDTH   (`MEM_WIDTH),
    .BITADDR (`MEM_BITADDR),
    .NUMADDR (`MEM_NUMADDR),
    .DELAY   (`MEM_T1_DELAY)
  ) i_t1_mem_1r2w (
    .clk     (clk),
    .t1_rd   (t1_rd),
    .t1_wr_a (t1_wr_a),
    .t1_wr_b (t1_wr_b),
    .t1_dout (t1_dout)
  );

endmodule

`default_nettype wire

// File: tb_mem1r2w_model.sv
`default_nettype none

`include "mem1r2w_params.svh"

module tb_mem1r2w_model
  import mem1r2w_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  rd_req_t     rd_req,
  input  wr_req_t     wr_req0,
  input  wr_req_t     wr_req1,
  input  rd_rsp_t     rd_rsp,
  output int unsigned pending,
  output logic        check_failed
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LAT = `MEM_T1_DELAY + `MEM_FLOPOUT;  // Read to valid, in cycles

  logic [`MEM_WIDTH-1:0] shadow [`MEM_NUMADDR];
  logic [`MEM_WIDTH-1:0] exp_q [$];
  logic [`MEM_WIDTH-1:0] exp_head;  // Oldest outstanding read result
  logic [LAT-1:0]        exp_vld_sr;
  logic                  exp_vld;
  bit                    fail_rst;
  bit                    fail_vld;
  bit                    fail_data;

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_vld_sr <= '0;
    end else begin
      exp_vld_sr <= (exp_vld_sr << 1) | LAT'(rd_req.read);
    end
  end

  assign exp_vld = exp_vld_sr[LAT-1];

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_q.delete();
      exp_head <= '0;
      pending  <= 0;
    end else begin
      if (exp_vld && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      // Read sees the contents from before this edge's writes
      if (rd_req.read) begin
        exp_q.push_back(shadow[rd_req.adr]);
      end
      if (wr_req0.write) begin
        for (int b = 0; b < `MEM_WIDTH; b++) begin
          if (wr_req0.bw[b]) begin
            shadow[wr_req0.adr][b] = wr_req0.din[b];
          end
        end
      end
      // Port B lands last, so it wins on a shared address
      if (wr_req1.write) begin
        for (int b = 0; b < `MEM_WIDTH; b++) begin
          if (wr_req1.bw[b]) begin
            shadow[wr_req1.adr][b] = wr_req1.din[b];
          end
        end
      end
      exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
      pending  <= exp_q.size();
    end
  end

  a_reset_vld: assert property (@(posedge clk) !arst_n |-> !rd_rsp.vld)
    else begin
      $display("Fail at %0t: rd_rsp.vld high while reset is active", $time);
      fail_rst = 1'b1;
    end

  a_vld_timing: assert property (@(posedge clk) disable iff (!arst_n)
    rd_rsp.vld == exp_vld)
    else begin
      $display("Fail at %0t: rd_rsp.vld is %b, expected %b", $time,
               $sampled(rd_rsp.vld), $sampled(exp_vld));
      fail_vld = 1'b1;
    end

  a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
    rd_rsp.vld |-> (rd_rsp.dout == exp_head))
    else begin
      $display("Fail at %0t: rd_rsp.dout is %h, expected %h", $time,
               $sampled(rd_rsp.dout), $sampled(exp_head));
      fail_data = 1'b1;
    end

  assign check_failed = fail_rst | fail_vld | fail_data;

endmodule

`default_nettype wire

// File: tb_mem1r2w_top.sv
`default_nettype none

`include "mem1r2w_params.svh"

module tb_mem1r2w_top
  import mem1r2w_pkg::*;
#(
  parameter int unsigned SEED = 55738
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 60;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int MAX_CYCLES      = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 3 / 2;
  localparam int RAND_ADR_MAX    = 63;  // Narrow range, more collisions

  localparam logic [`MEM_WIDTH-1:0] FULL_MASK = '1;

  logic        clk;
  logic        arst_n;
  rd_req_t     rd_req;
  wr_req_t     wr_req0;
  wr_req_t     wr_req1;
  rd_rsp_t     rd_rsp;
  int unsigned pending;
  logic        check_failed;
  int          cycle_cnt;

  bit                      written [`MEM_NUMADDR];
  logic [`MEM_BITADDR-1:0] written_list [$];

  always #20 clk = ~clk;

  mem1r2w_top i_mem1r2w_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .rd_req  (rd_req),
    .wr_req0 (wr_req0),
    .wr_req1 (wr_req1),
    .rd_rsp  (rd_rsp)
  );

  tb_mem1r2w_model i_tb_mem1r2w_model (
    .clk          (clk),
    .arst_n       (arst_n),
    .rd_req       (rd_req),
    .wr_req0      (wr_req0),
    .wr_req1      (wr_req1),
    .rd_rsp       (rd_rsp),
    .pending      (pending),
    .check_failed (check_failed)
  );

  function automatic rd_req_t read_of(input logic [`MEM_BITADDR-1:0] adr);
    return '{read: 1'b1, adr: adr};
  endfunction

  function automatic wr_req_t write_of(
    input logic [`MEM_BITADDR-1:0] adr,
    input logic [`MEM_WIDTH-1:0]   din,
    input logic [`MEM_WIDTH-1:0]   bw
  );
    return '{write: 1'b1, adr: adr, din: din, bw: bw};
  endfunction

  function automatic wr_req_t random_write();
    wr_req_t w;
    w = '0;
    if ($urandom_range(0, 99) < 50) begin
      w.write = 1'b1;
      w.adr   = `MEM_BITADDR'($urandom_range(0, RAND_ADR_MAX));
      w.din   = `MEM_WIDTH'($urandom);
      w.bw    = written[w.adr] ? `MEM_WIDTH'($urandom) : FULL_MASK;  // First write fills all
    end
    return w;
  endfunction

  task automatic note_written(input logic [`MEM_BITADDR-1:0] adr);
    if (!written[adr]) begin
      written[adr] = 1'b1;
      written_list.push_back(adr);
    end
  endtask

  task automatic drive_cycle(input rd_req_t r, input wr_req_t w0, input wr_req_t w1);
    @(negedge clk);
    rd_req  = r;
    wr_req0 = w0;
    wr_req1 = w1;
    if (w0.write) note_written(w0.adr);
    if (w1.write) note_written(w1.adr);
  endtask

  task automatic random_cycle();
    rd_req_t r;
    wr_req_t w0;
    wr_req_t w1;
    r = '0;
    if (written_list.size() != 0 && $urandom_range(0, 99) < 70) begin
      r = read_of(written_list[$urandom_range(0, written_list.size() - 1)]);
    end
    w0 = random_write();
    w1 = random_write();
    drive_cycle(r, w0, w1);
  endtask

  task automatic run_directed();
    drive_cycle('0, write_of(8'h10, 15'h1234, FULL_MASK), '0);
    drive_cycle('0, '0, write_of(8'h20, 15'h2abc, FULL_MASK));
    drive_cycle(read_of(8'h10), '0, '0);
    drive_cycle(read_of(8'h20), '0, '0);  // Back-to-back reads
    drive_cycle('0, write_of(8'h10, 15'h7fff, 15'h00f0), '0);
    drive_cycle('0, '0, write_of(8'h20, 15'h0000, 15'h7800));
    drive_cycle(read_of(8'h10), '0, '0);
    drive_cycle(read_of(8'h20), '0, '0);
    // Same address on both ports, masks overlap in bits 4..7
    drive_cycle('0, write_of(8'h30, 15'h5555, FULL_MASK), '0);
    drive_cycle('0, write_of(8'h30, 15'h7fff, 15'h0ff0), write_of(8'h30, 15'h0000, 15'h00ff));
    drive_cycle(read_of(8'h30), '0, '0);
    // Read and write of one address in one cycle
    drive_cycle(read_of(8'h20), write_of(8'h20, 15'h1357, FULL_MASK), '0);
    drive_cycle(read_of(8'h20), '0, '0);
    drive_cycle(read_of(8'h30), '0, write_of(8'h30, 15'h6a6a, 15'h3c3c));
    drive_cycle(read_of(8'h30), '0, '0);
    repeat (3) drive_cycle('0, '0, '0);
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("tests failed");
    $fatal(1, "cycle limit reached");
  end

  initial begin : failure_watch
    @(posedge check_failed);
    $display("tests failed");
    $fatal(1, "response check failed");
  end

  initial begin : stimulus
    clk     = 1'b0;
    arst_n  = 1'b0;
    rd_req  = '0;
    wr_req0 = '0;
    wr_req1 = '0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    run_directed();
    repeat (RANDOM_CYCLES) random_cycle();
    drive_cycle('0, '0, '0);
    while (pending != 0) @(negedge clk);
    @(negedge clk);
    if (check_failed) begin
      $display("tests failed");
      $fatal(1, "response check failed");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mem1r2w.f
+incdir+.
mem1r2w_pkg.sv
t1_mem_1r2w.sv
algo_1r2w_wrap.sv
mem1r2w_top.sv
tb_mem1r2w_model.sv
tb_mem1r2w_top.sv

// File: Makefile
# Verilator build for the 1R2W memory subsystem

VERILATOR ?= verilator
FILELIST  ?= mem1r2w.f
TOP       ?= tb_mem1r2w_top
RTL_TOP   ?= mem1r2w_top
SEED      ?= 55738
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

# Lint the design with the RTL top level as root
lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) \
		-f $(FILELIST) --top-module $(RTL_TOP)

# Build and run the testbench, a $fatal gives a failing exit status
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		-f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o $(TOP)

clean:
	rm -rf $(BUILD_DIR)
